// File: build.f
+incdir+include
design/isa_pkg.sv
design/exec_pkg.sv
design/muldiv_if.sv
design/alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exec_stage.sv
design/exec_top.sv
tb/tb_exec.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - include
    files:
      - design/isa_pkg.sv
      - design/exec_pkg.sv
      - design/muldiv_if.sv
      - design/alu.sv
      - design/mul_unit.sv
      - design/div_unit.sv
      - design/exec_stage.sv
      - design/exec_top.sv
      - target: test
        files:
          - tb/tb_exec.sv

// File: tb/tb_exec.sv
`include "exec_settings.svh"

module tb_exec;

    localparam int LIMIT = 400 * (`EXEC_MDU_CYCLES + 6);

    logic clk = 1'b0;
    logic arst_n, stall, flush, id_delay_slot, ex_delay_slot;
    exec_pkg::word_t id_pc, id_val1, id_val2, id_valt, hi_cur, lo_cur;
    isa_pkg::icode_e id_icode, ex_icode;
    isa_pkg::acode_e id_acode, ex_acode;
    exec_pkg::exc_code_t id_exc, ex_exc;
    exec_pkg::reg_idx_t id_dst, id_rt, id_rs, ex_dst, ex_rt, ex_rs;
    exec_pkg::word_t ex_pc, ex_valt, ex_result, hi_data, lo_data;
    logic hi_we, lo_we, busy;
    int cycles = 0;

    isa_pkg::icode_e imm_ops [12] = '{isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::SLTI,
        isa_pkg::SLTIU, isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LUI,
        isa_pkg::JAL, isa_pkg::COP0, isa_pkg::LW, isa_pkg::REGIMM};
    isa_pkg::acode_e spe_ops [19] = '{isa_pkg::ADD, isa_pkg::ADDU, isa_pkg::SUB,
        isa_pkg::SUBU, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::NOR, isa_pkg::SLT,
        isa_pkg::SLTU, isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::SLLV,
        isa_pkg::SRLV, isa_pkg::SRAV, isa_pkg::JALR, isa_pkg::MFHI, isa_pkg::MFLO};
    isa_pkg::acode_e mdu_ops [4] = '{isa_pkg::MULT, isa_pkg::MULTU, isa_pkg::DIV,
        isa_pkg::DIVU};

    exec_top u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // reference model of the single-cycle results
    function automatic exec_pkg::word_t model_result(isa_pkg::icode_e ic, isa_pkg::acode_e ac,
            exec_pkg::reg_idx_t rt, exec_pkg::word_t v1, exec_pkg::word_t v2,
            exec_pkg::word_t hi, exec_pkg::word_t lo);
        exec_pkg::word_t r;
        exec_pkg::word_t fill;
        logic [4:0] sh;
        r    = '0;
        sh   = v1[4:0];
        fill = v2[31] ? ~(32'hffffffff >> sh) : '0;  // sign bits for arithmetic shift
        case (ic)
            isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::LW: r = v1 + v2;
            isa_pkg::ANDI: r = v1 & v2;
            isa_pkg::ORI:  r = v1 | v2;
            isa_pkg::XORI: r = v1 ^ v2;
            isa_pkg::SLTI: r = {31'b0, (v1 ^ 32'h80000000) < (v2 ^ 32'h80000000)};
            isa_pkg::SLTIU: r = {31'b0, v1 < v2};
            isa_pkg::LUI, isa_pkg::JAL: r = v2;
            isa_pkg::COP0: r = v1;
            isa_pkg::REGIMM: r = (rt == 5'h10 || rt == 5'h11) ? v2 : '0;
            isa_pkg::SPE: begin
                case (ac)
                    isa_pkg::ADD, isa_pkg::ADDU: r = v1 + v2;
                    isa_pkg::SUB, isa_pkg::SUBU: r = v1 - v2;
                    isa_pkg::AND: r = v1 & v2;
                    isa_pkg::OR:  r = v1 | v2;
                    isa_pkg::XOR: r = v1 ^ v2;
                    isa_pkg::NOR: r = ~v1 & ~v2;
                    isa_pkg::SLT: r = {31'b0, (v1 ^ 32'h80000000) < (v2 ^ 32'h80000000)};
                    isa_pkg::SLTU: r = {31'b0, v1 < v2};
                    isa_pkg::SLL, isa_pkg::SLLV: r = v2 << sh;
                    isa_pkg::SRL, isa_pkg::SRLV: r = v2 >> sh;
                    isa_pkg::SRA, isa_pkg::SRAV: r = (v2 >> sh) | fill;
                    isa_pkg::JALR: r = v2;
                    isa_pkg::MFHI: r = hi;
                    isa_pkg::MFLO: r = lo;
                    default: r = '0;
                endcase
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic model_overflow(isa_pkg::icode_e ic, isa_pkg::acode_e ac,
            exec_pkg::word_t v1, exec_pkg::word_t v2);
        exec_pkg::word_t s;
        exec_pkg::word_t d;
        s = v1 + v2;
        d = v1 - v2;
        if (ic == isa_pkg::ADDI || (ic == isa_pkg::SPE && ac == isa_pkg::ADD))
            return (v1[31] == v2[31]) && (s[31] != v1[31]);
        if (ic == isa_pkg::SPE && ac == isa_pkg::SUB)
            return (v1[31] != v2[31]) && (d[31] != v1[31]);
        return 1'b0;
    endfunction

    // {hi, lo} from magnitudes with the sign fixed up afterwards
    function automatic exec_pkg::dword_t model_mdu(isa_pkg::acode_e ac, exec_pkg::word_t v1,
            exec_pkg::word_t v2);
        logic sgn;
        exec_pkg::word_t m1, m2, q, r;
        exec_pkg::dword_t p;
        sgn = ac inside {isa_pkg::MULT, isa_pkg::DIV, isa_pkg::MUL};
        m1  = (sgn && v1[31]) ? ~v1 + 1 : v1;
        m2  = (sgn && v2[31]) ? ~v2 + 1 : v2;
        if (ac inside {isa_pkg::MULT, isa_pkg::MULTU, isa_pkg::MUL}) begin
            p = {32'b0, m1} * {32'b0, m2};
            return (sgn && (v1[31] ^ v2[31])) ? ~p + 1 : p;
        end
        q = (m2 == 0) ? 32'hffffffff : m1 / m2;
        r = (m2 == 0) ? m1 : m1 % m2;
        if (sgn && (v1[31] ^ v2[31])) q = ~q + 1;
        if (sgn && v1[31]) r = ~r + 1;
        return {r, q};
    endfunction

    task automatic drive_op(isa_pkg::icode_e ic, isa_pkg::acode_e ac, exec_pkg::reg_idx_t rt,
            exec_pkg::word_t v1, exec_pkg::word_t v2, exec_pkg::exc_code_t exc);
        id_icode      <= ic;
        id_acode      <= ac;
        id_rt         <= rt;
        id_val1       <= v1;
        id_val2       <= v2;
        id_exc        <= exc;
        id_pc         <= $urandom;
        id_dst        <= 5'($urandom);
        id_rs         <= 5'($urandom);
        id_valt       <= $urandom;
        id_delay_slot <= 1'($urandom);
        hi_cur        <= $urandom;
        lo_cur        <= $urandom;
    endtask

    task automatic run_single(isa_pkg::icode_e ic, isa_pkg::acode_e ac, exec_pkg::reg_idx_t rt,
            exec_pkg::word_t v1, exec_pkg::word_t v2, exec_pkg::exc_code_t exc);
        exec_pkg::word_t exp_res;
        exec_pkg::exc_code_t exp_exc;
        @(posedge clk);
        drive_op(ic, ac, rt, v1, v2, exc);
        @(posedge clk);
        @(negedge clk);
        exp_res = model_result(ic, ac, rt, v1, v2, hi_cur, lo_cur);
        exp_exc = exc[5] ? exc : (model_overflow(ic, ac, v1, v2) ? `EXEC_EXC_OV : 6'h00);
        assert (ex_icode == ic && ex_result == exp_res)
            else fail_check($sformatf("%s/%s result %h, expected %h", ic.name(), ac.name(),
                ex_result, exp_res));
        assert (ex_exc == exp_exc)
            else fail_check($sformatf("%s/%s exc %h, expected %h", ic.name(), ac.name(),
                ex_exc, exp_exc));
        assert (ex_acode == ac && ex_pc == id_pc && ex_dst == id_dst && ex_rt == rt
            && ex_rs == id_rs && ex_valt == id_valt && ex_delay_slot == id_delay_slot)
            else fail_check("decode fields not carried to the ex outputs");
    endtask

    task automatic run_mdu(isa_pkg::icode_e ic, isa_pkg::acode_e ac, exec_pkg::word_t v1,
            exec_pkg::word_t v2);
        exec_pkg::dword_t exp;
        exec_pkg::word_t hi_seen, lo_seen, last_res;
        int we_cnt;
        we_cnt = 0;
        @(posedge clk);
        drive_op(ic, ac, 5'd0, v1, v2, 6'h00);
        @(posedge clk);
        id_icode <= isa_pkg::NOP;
        @(negedge clk);
        assert (busy) else fail_check("busy low after multiply/divide capture");
        while (busy) begin
            if (hi_we) begin
                we_cnt++;
                hi_seen = hi_data;
                lo_seen = lo_data;
            end
            assert (hi_we == lo_we) else fail_check("hi_we and lo_we differ");
            last_res = ex_result;  // the final busy cycle is the ack cycle
            @(negedge clk);
        end
        exp = model_mdu(ac, v1, v2);
        if (ac == isa_pkg::MUL) begin
            assert (we_cnt == 0 && last_res == exp[31:0])
                else fail_check($sformatf("MUL %h*%h gave %h, expected %h", v1, v2,
                    last_res, exp[31:0]));
        end else begin
            assert (we_cnt == 1 && hi_seen == exp[63:32] && lo_seen == exp[31:0])
                else fail_check($sformatf("%s %h,%h gave %0d pulses %h_%h, expected %h",
                    ac.name(), v1, v2, we_cnt, hi_seen, lo_seen, exp));
        end
    endtask

    initial begin
        exec_pkg::word_t snap_pc, snap_res, snap_valt;
        isa_pkg::icode_e snap_ic;
        isa_pkg::acode_e snap_ac;
        exec_pkg::exc_code_t snap_exc;
        exec_pkg::reg_idx_t snap_rt, snap_dst, snap_rs;
        logic snap_ds;
        void'($urandom(32'h15929cd7));
        arst_n        = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        id_pc         = '0;
        id_icode      = isa_pkg::NOP;
        id_acode      = isa_pkg::SLL;
        id_exc        = '0;
        id_dst        = '0;
        id_rt         = '0;
        id_rs         = '0;
        id_val1       = '0;
        id_val2       = '0;
        id_valt       = '0;
        id_delay_slot = 1'b0;
        hi_cur        = '0;
        lo_cur        = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!hi_we && !lo_we && !busy && ex_icode == isa_pkg::NOP)
            else fail_check("outputs not idle after reset");

        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(1, 0))
                run_single(imm_ops[$urandom_range(11, 0)], isa_pkg::ADD,
                    ($urandom_range(2, 0) == 0) ? 5'h03 : 5'h10 + 5'($urandom_range(1, 0)),
                    $urandom, $urandom,
                    ($urandom_range(3, 0) == 0) ? 6'h20 | 6'($urandom) : 6'h00);
            else
                run_single(isa_pkg::SPE, spe_ops[$urandom_range(18, 0)], 5'd0, $urandom,
                    $urandom, ($urandom_range(3, 0) == 0) ? 6'h20 | 6'($urandom) : 6'h00);
        end

        // forced overflow and exception priority
        run_single(isa_pkg::SPE, isa_pkg::ADD, 5'd0, 32'h7fffffff, 32'h1, 6'h00);
        run_single(isa_pkg::ADDI, isa_pkg::ADD, 5'd0, 32'h80000000, 32'hffffffff, 6'h00);
        run_single(isa_pkg::SPE, isa_pkg::SUB, 5'd0, 32'h80000000, 32'h1, 6'h00);
        run_single(isa_pkg::SPE, isa_pkg::ADD, 5'd0, 32'h5, 32'h7, 6'h00);
        run_single(isa_pkg::SPE, isa_pkg::ADD, 5'd0, 32'h7fffffff, 32'h1, 6'h21);
        run_single(isa_pkg::SPE, isa_pkg::MFHI, 5'd0, $urandom, $urandom, 6'h00);
        run_single(isa_pkg::SPE, isa_pkg::MFLO, 5'd0, $urandom, $urandom, 6'h00);

        run_mdu(isa_pkg::SPE, isa_pkg::DIV, 32'hfffffff9, 32'h2);
        run_mdu(isa_pkg::SPE, isa_pkg::DIV, 32'h80000000, 32'hffffffff);
        run_mdu(isa_pkg::SPE, isa_pkg::DIV, 32'hfffffff9, 32'h0);
        run_mdu(isa_pkg::SPE, isa_pkg::DIVU, $urandom, 32'h0);
        for (int i = 0; i < 40; i++) begin
            if (i % 5 == 4)
                run_mdu(isa_pkg::SPE2, isa_pkg::MUL, $urandom, $urandom);
            else
                run_mdu(isa_pkg::SPE, mdu_ops[$urandom_range(3, 0)], $urandom,
                    (i % 8 == 3) ? 32'h0 : $urandom);
        end

        // stall holds every registered output
        run_single(isa_pkg::SPE, isa_pkg::ADDU, 5'd0, $urandom, $urandom, 6'h00);
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        snap_pc   = ex_pc;
        snap_res  = ex_result;
        snap_ic   = ex_icode;
        snap_ac   = ex_acode;
        snap_exc  = ex_exc;
        snap_dst  = ex_dst;
        snap_rt   = ex_rt;
        snap_rs   = ex_rs;
        snap_valt = ex_valt;
        snap_ds   = ex_delay_slot;
        @(posedge clk);
        drive_op(isa_pkg::ORI, isa_pkg::ADD, 5'd7, $urandom, $urandom, 6'h00);
        repeat (4) begin
            @(negedge clk);
            assert (ex_pc == snap_pc && ex_result == snap_res && ex_icode == snap_ic
                && ex_acode == snap_ac && ex_exc == snap_exc && ex_dst == snap_dst
                && ex_rt == snap_rt && ex_rs == snap_rs && ex_valt == snap_valt
                && ex_delay_slot == snap_ds) else fail_check("outputs moved during stall");
        end

        // flush wins over stall
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        id_icode <= isa_pkg::NOP;
        @(negedge clk);
        assert (ex_icode == isa_pkg::NOP && ex_result == '0) else fail_check("flush not a NOP");

        // flush cancels a divide
        @(posedge clk);
        drive_op(isa_pkg::SPE, isa_pkg::DIV, 5'd0, $urandom, $urandom, 6'h00);
        @(posedge clk);
        id_icode <= isa_pkg::NOP;
        repeat (5) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (2 * `EXEC_MDU_CYCLES) begin
            @(negedge clk);
            assert (!hi_we && !busy && ex_icode == isa_pkg::NOP)
                else fail_check("flushed divide still active");
        end
        run_mdu(isa_pkg::SPE, isa_pkg::DIVU, $urandom, $urandom);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: design/exec_top.sv
module exec_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  exec_pkg::word_t     id_pc,
    input  isa_pkg::icode_e     id_icode,
    input  isa_pkg::acode_e     id_acode,
    input  exec_pkg::exc_code_t id_exc,
    input  exec_pkg::reg_idx_t  id_dst,
    input  exec_pkg::reg_idx_t  id_rt,
    input  exec_pkg::reg_idx_t  id_rs,
    input  exec_pkg::word_t     id_val1,
    input  exec_pkg::word_t     id_val2,
    input  exec_pkg::word_t     id_valt,
    input  logic                id_delay_slot,
    input  exec_pkg::word_t     hi_cur,
    input  exec_pkg::word_t     lo_cur,
    output exec_pkg::word_t     ex_pc,
    output isa_pkg::icode_e     ex_icode,
    output isa_pkg::acode_e     ex_acode,
    output exec_pkg::exc_code_t ex_exc,
    output exec_pkg::reg_idx_t  ex_dst,
    output exec_pkg::reg_idx_t  ex_rt,
    output exec_pkg::reg_idx_t  ex_rs,
    output exec_pkg::word_t     ex_valt,
    output logic                ex_delay_slot,
    output exec_pkg::word_t     ex_result,
    output exec_pkg::word_t     hi_data,
    output exec_pkg::word_t     lo_data,
    output logic                hi_we,
    output logic                lo_we,
    output logic                busy
);

    exec_pkg::word_t ex_val1;
    exec_pkg::word_t ex_val2;
    exec_pkg::word_t alu_result;
    logic            alu_overflow;

    muldiv_if mul_link ();
    muldiv_if div_link ();

    exec_stage u_stage (
        .mul (mul_link.requester),
        .div (div_link.requester),
        .*
    );

    alu u_alu (
        .icode    (ex_icode),
        .acode    (ex_acode),
        .rt       (ex_rt),
        .val1     (ex_val1),
        .val2     (ex_val2),
        .hi_cur   (hi_cur),
        .lo_cur   (lo_cur),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    mul_unit u_mul (
        .clk    (clk),
        .arst_n (arst_n),
        .port   (mul_link.worker)
    );

    div_unit u_div (
        .clk    (clk),
        .arst_n (arst_n),
        .port   (div_link.worker)
    );

endmodule

// File: design/exec_stage.sv
`include "exec_settings.svh"

module exec_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  exec_pkg::word_t     id_pc,
    input  isa_pkg::icode_e     id_icode,
    input  isa_pkg::acode_e     id_acode,
    input  exec_pkg::exc_code_t id_exc,
    input  exec_pkg::reg_idx_t  id_dst,
    input  exec_pkg::reg_idx_t  id_rt,
    input  exec_pkg::reg_idx_t  id_rs,
    input  exec_pkg::word_t     id_val1,
    input  exec_pkg::word_t     id_val2,
    input  exec_pkg::word_t     id_valt,
    input  logic                id_delay_slot,
    input  exec_pkg::word_t     alu_result,
    input  logic                alu_overflow,
    output exec_pkg::word_t     ex_val1,
    output exec_pkg::word_t     ex_val2,
    output exec_pkg::word_t     ex_pc,
    output isa_pkg::icode_e     ex_icode,
    output isa_pkg::acode_e     ex_acode,
    output exec_pkg::exc_code_t ex_exc,
    output exec_pkg::reg_idx_t  ex_dst,
    output exec_pkg::reg_idx_t  ex_rt,
    output exec_pkg::reg_idx_t  ex_rs,
    output exec_pkg::word_t     ex_valt,
    output logic                ex_delay_slot,
    output exec_pkg::word_t     ex_result,
    output exec_pkg::word_t     hi_data,
    output exec_pkg::word_t     lo_data,
    output logic                hi_we,
    output logic                lo_we,
    output logic                busy,
    muldiv_if.requester         mul,
    muldiv_if.requester         div
);

    localparam int W = `EXEC_WORD_W;

    function automatic exec_pkg::mdu_op_e mdu_decode(isa_pkg::icode_e ic, isa_pkg::acode_e ac);
        exec_pkg::mdu_op_e op;
        op = exec_pkg::MDU_NONE;
        if (ic == isa_pkg::SPE2 && ac == isa_pkg::MUL) begin
            op = exec_pkg::MDU_MUL;
        end else if (ic == isa_pkg::SPE) begin
            case (ac)
                isa_pkg::MULT:  op = exec_pkg::MDU_MULT;
                isa_pkg::MULTU: op = exec_pkg::MDU_MULTU;
                isa_pkg::DIV:   op = exec_pkg::MDU_DIV;
                isa_pkg::DIVU:  op = exec_pkg::MDU_DIVU;
                default: ;
            endcase
        end
        return op;
    endfunction

    function automatic exec_pkg::word_t magnitude(exec_pkg::word_t x);
        return x[W-1] ? -x : x;
    endfunction

    exec_pkg::exc_code_t  exc_q;
    exec_pkg::mdu_op_e    op;
    exec_pkg::mdu_state_e state;  // run = request outstanding
    logic                 use_mul;
    logic                 is_signed;
    logic                 sign_diff;
    logic                 ack;
    logic                 done;
    exec_pkg::word_t      opa;
    exec_pkg::word_t      opb;
    exec_pkg::dword_t     prod_fix;
    exec_pkg::word_t      quo_fix;
    exec_pkg::word_t      rem_fix;

    assign op        = mdu_decode(ex_icode, ex_acode);
    assign use_mul   = op inside {exec_pkg::MDU_MULT, exec_pkg::MDU_MULTU, exec_pkg::MDU_MUL};
    assign is_signed = op inside {exec_pkg::MDU_MULT, exec_pkg::MDU_DIV, exec_pkg::MDU_MUL};
    assign sign_diff = is_signed && (ex_val1[W-1] ^ ex_val2[W-1]);
    assign ack       = use_mul ? mul.ack : div.ack;
    assign busy      = (state == exec_pkg::ST_RUN);
    assign done      = busy && ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_pc         <= '0;
            ex_icode      <= isa_pkg::NOP;
            ex_acode      <= isa_pkg::acode_e'(6'd0);
            exc_q         <= '0;
            ex_dst        <= '0;
            ex_rt         <= '0;
            ex_rs         <= '0;
            ex_val1       <= '0;
            ex_val2       <= '0;
            ex_valt       <= '0;
            ex_delay_slot <= 1'b0;
            state         <= exec_pkg::ST_IDLE;
        end else if (flush || (!stall && !busy)) begin
            // flush loads a nop bubble
            ex_pc         <= flush ? '0 : id_pc;
            ex_icode      <= flush ? isa_pkg::NOP : id_icode;
            ex_acode      <= flush ? isa_pkg::acode_e'(6'd0) : id_acode;
            exc_q         <= flush ? '0 : id_exc;
            ex_dst        <= flush ? '0 : id_dst;
            ex_rt         <= flush ? '0 : id_rt;
            ex_rs         <= flush ? '0 : id_rs;
            ex_val1       <= flush ? '0 : id_val1;
            ex_val2       <= flush ? '0 : id_val2;
            ex_valt       <= flush ? '0 : id_valt;
            ex_delay_slot <= flush ? 1'b0 : id_delay_slot;
            if (flush || mdu_decode(id_icode, id_acode) == exec_pkg::MDU_NONE) begin
                state <= exec_pkg::ST_IDLE;
            end else begin
                state <= exec_pkg::ST_RUN;
            end
        end else if (done) begin
            state <= exec_pkg::ST_DONE;
        end
    end

    assign ex_exc = exc_q[5] ? exc_q : (alu_overflow ? `EXEC_EXC_OV : '0);

    // units see magnitudes for the signed ops
    assign opa     = is_signed ? magnitude(ex_val1) : ex_val1;
    assign opb     = is_signed ? magnitude(ex_val2) : ex_val2;
    assign mul.a   = opa;
    assign mul.b   = opb;
    assign div.a   = opa;
    assign div.b   = opb;
    assign mul.req = busy && use_mul && !mul.ack;  // falls in the ack cycle
    assign div.req = busy && !use_mul && !div.ack;

    assign prod_fix = sign_diff ? -mul.res : mul.res;
    assign quo_fix  = sign_diff ? -div.res[W-1:0] : div.res[W-1:0];
    assign rem_fix  = (is_signed && ex_val1[W-1]) ? -div.res[2*W-1:W] : div.res[2*W-1:W];

    assign {hi_data, lo_data} = use_mul ? prod_fix : {rem_fix, quo_fix};
    assign hi_we     = done && (op != exec_pkg::MDU_MUL) && !flush;
    assign lo_we     = hi_we;
    assign ex_result = (done && op == exec_pkg::MDU_MUL) ? prod_fix[W-1:0] : alu_result;

endmodule

// File: design/div_unit.sv
`include "exec_settings.svh"

module div_unit (
    input logic      clk,
    input logic      arst_n,
    muldiv_if.worker port
);

    localparam int W  = `EXEC_WORD_W;
    localparam int CW = $clog2(`EXEC_MDU_CYCLES);

    exec_pkg::mdu_state_e state;
    logic [CW-1:0]        cnt;
    exec_pkg::word_t      divisor;
    exec_pkg::word_t      quo;      // dividend bits shift out, quotient bits shift in
    exec_pkg::word_t      rem;
    logic [W:0]           shifted;
    logic [W:0]           trial;

    assign shifted  = {rem, quo[W-1]};
    assign trial    = shifted - {1'b0, divisor};
    assign port.ack = (state == exec_pkg::ST_DONE);
    assign port.res = {rem, quo};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= exec_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::ST_IDLE: begin
                    cnt <= '0;
                    if (port.req) state <= exec_pkg::ST_RUN;
                end
                exec_pkg::ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (!port.req) begin
                        state <= exec_pkg::ST_IDLE;
                    end else if (cnt == CW'(`EXEC_MDU_CYCLES - 1)) begin
                        state <= exec_pkg::ST_DONE;
                    end
                end
                default: begin
                    if (!port.req) state <= exec_pkg::ST_IDLE;  // handshake closed
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exec_pkg::ST_IDLE) begin
            divisor <= port.b;
            quo     <= port.a;
            rem     <= '0;
        end else if (state == exec_pkg::ST_RUN) begin
            if (trial[W]) begin
                rem <= shifted[W-1:0];  // restore
                quo <= {quo[W-2:0], 1'b0};
            end else begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end
        end
    end

endmodule

// File: design/mul_unit.sv
`include "exec_settings.svh"

module mul_unit (
    input logic      clk,
    input logic      arst_n,
    muldiv_if.worker port
);

    localparam int W  = `EXEC_WORD_W;
    localparam int CW = $clog2(`EXEC_MDU_CYCLES);

    exec_pkg::mdu_state_e state;
    logic [CW-1:0]        cnt;
    exec_pkg::word_t      mcand;
    exec_pkg::dword_t     prod;     // upper half sums, lower half shifts out multiplier
    logic [W:0]           partial;

    assign partial  = {1'b0, prod[2*W-1:W]} + (prod[0] ? {1'b0, mcand} : '0);
    assign port.ack = (state == exec_pkg::ST_DONE);
    assign port.res = prod;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= exec_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::ST_IDLE: begin
                    cnt <= '0;
                    if (port.req) state <= exec_pkg::ST_RUN;
                end
                exec_pkg::ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (!port.req) begin
                        state <= exec_pkg::ST_IDLE;  // cancelled
                    end else if (cnt == CW'(`EXEC_MDU_CYCLES - 1)) begin
                        state <= exec_pkg::ST_DONE;
                    end
                end
                default: begin
                    if (!port.req) state <= exec_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exec_pkg::ST_IDLE) begin
            mcand <= port.a;
            prod  <= {{W{1'b0}}, port.b};
        end else if (state == exec_pkg::ST_RUN) begin
            prod <= {partial, prod[W-1:1]};
        end
    end

endmodule

// File: design/alu.sv
`include "exec_settings.svh"

module alu (
    input  isa_pkg::icode_e    icode,
    input  isa_pkg::acode_e    acode,
    input  exec_pkg::reg_idx_t rt,
    input  exec_pkg::word_t    val1,
    input  exec_pkg::word_t    val2,
    input  exec_pkg::word_t    hi_cur,
    input  exec_pkg::word_t    lo_cur,
    output exec_pkg::word_t    result,
    output logic               overflow
);

    localparam int W = `EXEC_WORD_W;

    logic [W:0]      ext_sum;   // one extra sign bit for overflow
    logic [W:0]      ext_diff;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    exec_pkg::word_t addr;

    assign ext_sum  = {val1[W-1], val1} + {val2[W-1], val2};
    assign ext_diff = {val1[W-1], val1} - {val2[W-1], val2};
    assign shamt    = val1[4:0];
    assign lt_s     = $signed(val1) < $signed(val2);
    assign lt_u     = val1 < val2;
    assign addr     = val1 + val2;

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (icode)
            isa_pkg::ADDI: begin
                result   = ext_sum[W-1:0];
                overflow = ext_sum[W] ^ ext_sum[W-1];
            end
            isa_pkg::ADDIU, isa_pkg::LB, isa_pkg::LBU, isa_pkg::LH, isa_pkg::LHU,
            isa_pkg::LW, isa_pkg::SB, isa_pkg::SH, isa_pkg::SW: result = addr;
            isa_pkg::ANDI:  result = val1 & val2;
            isa_pkg::ORI:   result = val1 | val2;
            isa_pkg::XORI:  result = val1 ^ val2;
            isa_pkg::SLTI:  result = W'(lt_s);
            isa_pkg::SLTIU: result = W'(lt_u);
            isa_pkg::LUI,
            isa_pkg::JAL:   result = val2;  // upper immediate or return pc
            isa_pkg::COP0:  result = val1;  // mfc0
            isa_pkg::REGIMM: begin
                case (isa_pkg::regimm_e'(rt))
                    isa_pkg::BGEZAL,
                    isa_pkg::BLTZAL: result = val2;
                    default: ;
                endcase
            end
            isa_pkg::SPE: begin
                case (acode)
                    isa_pkg::ADD: begin
                        result   = ext_sum[W-1:0];
                        overflow = ext_sum[W] ^ ext_sum[W-1];
                    end
                    isa_pkg::SUB: begin
                        result   = ext_diff[W-1:0];
                        overflow = ext_diff[W] ^ ext_diff[W-1];
                    end
                    isa_pkg::ADDU: result = addr;
                    isa_pkg::SUBU: result = val1 - val2;
                    isa_pkg::AND:  result = val1 & val2;
                    isa_pkg::OR:   result = val1 | val2;
                    isa_pkg::XOR:  result = val1 ^ val2;
                    isa_pkg::NOR:  result = ~(val1 | val2);
                    isa_pkg::SLT:  result = W'(lt_s);
                    isa_pkg::SLTU: result = W'(lt_u);
                    isa_pkg::SLL,
                    isa_pkg::SLLV: result = val2 << shamt;
                    isa_pkg::SRL,
                    isa_pkg::SRLV: result = val2 >> shamt;
                    isa_pkg::SRA,
                    isa_pkg::SRAV: result = $signed(val2) >>> shamt;
                    isa_pkg::JALR: result = val2;
                    isa_pkg::MFHI: result = hi_cur;
                    isa_pkg::MFLO: result = lo_cur;
                    default: ;  // mult/div answer through the units
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: design/muldiv_if.sv
interface muldiv_if;

    logic             req;
    exec_pkg::word_t  a;
    exec_pkg::word_t  b;
    logic             ack;
    exec_pkg::dword_t res;  // valid while ack is high

    modport requester (
        output req, a, b,
        input  ack, res
    );

    modport worker (
        input  req, a, b,
        output ack, res
    );

endinterface

// File: design/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`EXEC_WORD_W-1:0]   word_t;
    typedef logic [2*`EXEC_WORD_W-1:0] dword_t;  // {hi, lo}
    typedef logic [4:0]                reg_idx_t;
    typedef logic [5:0]                exc_code_t;  // bit 5 marks an earlier-stage code

    typedef enum logic [2:0] {
        MDU_NONE,
        MDU_MULT,
        MDU_MULTU,
        MDU_DIV,
        MDU_DIVU,
        MDU_MUL
    } mdu_op_e;

    // shared by both iterative units and the stage sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } mdu_state_e;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    // primary opcodes as handed over by decode
    typedef enum logic [5:0] {
        NOP    = 6'h00,
        REGIMM = 6'h01,
        JAL    = 6'h03,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        SLTI   = 6'h0a,
        SLTIU  = 6'h0b,
        ANDI   = 6'h0c,
        ORI    = 6'h0d,
        XORI   = 6'h0e,
        LUI    = 6'h0f,
        COP0   = 6'h10,
        SPE2   = 6'h1c,
        LB     = 6'h20,
        LH     = 6'h21,
        LW     = 6'h23,
        LBU    = 6'h24,
        LHU    = 6'h25,
        SB     = 6'h28,
        SH     = 6'h29,
        SW     = 6'h2b,
        SPE    = 6'h3f   // special remapped so that zero stays nop
    } icode_e;

    // function field of special and special2
    typedef enum logic [5:0] {
        SLL   = 6'h00,
        SRL   = 6'h02,
        SRA   = 6'h03,
        SLLV  = 6'h04,
        SRLV  = 6'h06,
        SRAV  = 6'h07,
        JALR  = 6'h09,
        MFHI  = 6'h10,
        MFLO  = 6'h12,
        MULT  = 6'h18,
        MULTU = 6'h19,
        DIV   = 6'h1a,
        DIVU  = 6'h1b,
        ADD   = 6'h20,
        ADDU  = 6'h21,
        SUB   = 6'h22,
        SUBU  = 6'h23,
        AND   = 6'h24,
        OR    = 6'h25,
        XOR   = 6'h26,
        NOR   = 6'h27,
        SLT   = 6'h2a,
        SLTU  = 6'h2b,
        MUL   = 6'h3e    // special2 mul moved off the srl code
    } acode_e;

    // only the linking regimm branches matter here
    typedef enum logic [4:0] {
        BLTZAL = 5'h10,
        BGEZAL = 5'h11
    } regimm_e;

endpackage

// File: include/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath word
`define EXEC_WORD_W 32

// iterations of the shift-add and restoring loops
`define EXEC_MDU_CYCLES 32

`define EXEC_EXC_OV 6'h2c  // arithmetic overflow

`endif
